// ==== verilog/flac_defs.svh ====
`ifndef FLAC_DEFS_SVH
`define FLAC_DEFS_SVH

// Width of one input audio sample
`define SAMPLE_WIDTH 16

// Signed residual width
// Four guard bits above the sample cover the order 4 coefficient magnitude sum of 16
`define RESIDUAL_WIDTH 20

// Block sum of absolute residuals
// Wide enough for blocks of up to 4096 full-scale residuals
`define SUM_WIDTH 32

// Fixed predictor orders 0 to 4
`define NUM_ORDERS 5

`endif

// ==== verilog/flacPkg.sv ====
`default_nettype none

`include "flac_defs.svh"

package flacPkg;

    // Signed input audio sample
    typedef logic signed [`SAMPLE_WIDTH-1:0] sampleT;

    // Signed prediction residual, never wraps for 16-bit input
    typedef logic signed [`RESIDUAL_WIDTH-1:0] residualT;

    // Unsigned running sum of absolute residuals
    typedef logic [`SUM_WIDTH-1:0] sumT;

    // Index of a predictor order
    typedef logic [$clog2(`NUM_ORDERS)-1:0] orderT;

endpackage

`default_nettype wire

// ==== verilog/fixedEncoder.sv ====
`default_nettype none

module fixedEncoder #(
    parameter int order = 0
) (
    input  logic              iClock,
    input  logic              arstN,
    input  logic              iEnable,
    input  logic              iBlockStart,
    input  logic              iBlockEnd,
    input  flacPkg::sampleT   iSample,
    output flacPkg::residualT oResidual,
    output logic              oResidualValid,
    output logic              oResidualLast
);

    import flacPkg::*;

    // Order as a counter-width value for the warm-up compare
    localparam logic [2:0] orderBits = 3'(order);

    // Previous four samples, index 0 is the most recent
    sampleT history [4];

    // Samples seen so far in the current block, saturates at the order
    logic [2:0] warmCount;
    logic [2:0] sampleIndex;
    logic       warmUp;

    // Sign-extended taps, tap0 is the incoming sample
    residualT tap0;
    residualT tap1;
    residualT tap2;
    residualT tap3;
    residualT tap4;

    // Partial terms of the binomial difference
    residualT outerSum;
    residualT innerShift;
    residualT middleTap;

    // Pipeline registers
    residualT termOuter;
    residualT termInner;
    residualT termMiddle;
    residualT termDiff;
    residualT termMiddleDly;
    logic     valid1;
    logic     last1;
    logic     valid2;
    logic     last2;

    // A block start always counts as the first sample of its block
    assign sampleIndex = iBlockStart ? 3'd0 : warmCount;
    assign warmUp      = sampleIndex < orderBits;

    always_comb begin
        tap0 = iSample;
        tap1 = history[0];
        tap2 = history[1];
        tap3 = history[2];
        tap4 = history[3];
        // Order 0 is the sample itself
        outerSum   = tap0;
        innerShift = '0;
        middleTap  = '0;
        case (order)
            1: begin
                outerSum = tap0 - tap1;
            end
            2: begin
                // x0 - 2x1 + x2
                outerSum   = tap0 + tap2;
                innerShift = tap1 <<< 1;
            end
            3: begin
                // x0 - 3x1 + 3x2 - x3
                outerSum   = tap0 - tap3;
                innerShift = (tap1 <<< 1) + tap1;
                middleTap  = (tap2 <<< 1) + tap2;
            end
            4: begin
                // x0 - 4x1 + 6x2 - 4x3 + x4
                outerSum   = tap0 + tap4;
                innerShift = (tap1 <<< 2) + (tap3 <<< 2);
                middleTap  = (tap2 <<< 2) + (tap2 <<< 1);
            end
            default: begin
                outerSum = tap0;
            end
        endcase
        // Warm-up samples pass straight through
        if (warmUp) begin
            outerSum   = tap0;
            innerShift = '0;
            middleTap  = '0;
        end
    end

    // History window and warm-up count only move on enable
    always_ff @(posedge iClock or negedge arstN) begin
        if (!arstN) begin
            warmCount <= '0;
            for (int k = 0; k < 4; k++) begin
                history[k] <= '0;
            end
        end else if (iEnable) begin
            history[0] <= iSample;
            for (int k = 1; k < 4; k++) begin
                history[k] <= history[k-1];
            end
            if (iBlockStart) begin
                warmCount <= 3'd1;
            end else if (warmCount < orderBits) begin
                warmCount <= warmCount + 3'd1;
            end
        end
    end

    // Three-stage residual pipeline, advances every cycle
    always_ff @(posedge iClock or negedge arstN) begin
        if (!arstN) begin
            termOuter      <= '0;
            termInner      <= '0;
            termMiddle     <= '0;
            termDiff       <= '0;
            termMiddleDly  <= '0;
            oResidual      <= '0;
            valid1         <= 1'b0;
            last1          <= 1'b0;
            valid2         <= 1'b0;
            last2          <= 1'b0;
            oResidualValid <= 1'b0;
            oResidualLast  <= 1'b0;
        end else begin
            // Stage 1 partial terms
            termOuter  <= outerSum;
            termInner  <= innerShift;
            termMiddle <= middleTap;
            valid1     <= iEnable;
            last1      <= iEnable & iBlockEnd;
            // Stage 2 difference
            termDiff      <= termOuter - termInner;
            termMiddleDly <= termMiddle;
            valid2        <= valid1;
            last2         <= last1;
            // Stage 3 residual
            oResidual      <= termDiff + termMiddleDly;
            oResidualValid <= valid2;
            oResidualLast  <= last2;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/residualAccumulator.sv ====
`default_nettype none

module residualAccumulator (
    input  logic              iClock,
    input  logic              arstN,
    input  flacPkg::residualT iResidual,
    input  logic              iResidualValid,
    input  logic              iResidualLast,
    output flacPkg::sumT      oBlockSum,
    output logic              oSumValid
);

    import flacPkg::*;

    // Magnitude of the incoming residual
    residualT absResidual;
    sumT      absExtended;
    sumT      runningTotal;
    sumT      nextTotal;

    // Largest order 4 magnitude stays below 2^19, so negation is safe
    assign absResidual = iResidual[$bits(residualT)-1] ? -iResidual : iResidual;

    // Zero extend the magnitude into the sum width
    assign absExtended = sumT'($unsigned(absResidual));
    assign nextTotal   = runningTotal + absExtended;

    always_ff @(posedge iClock or negedge arstN) begin
        if (!arstN) begin
            runningTotal <= '0;
            oBlockSum    <= '0;
            oSumValid    <= 1'b0;
        end else begin
            // One-cycle pulse after the last residual of a block
            oSumValid <= iResidualValid & iResidualLast;
            if (iResidualValid) begin
                if (iResidualLast) begin
                    // Present the block total and start over
                    oBlockSum    <= nextTotal;
                    runningTotal <= '0;
                end else begin
                    runningTotal <= nextTotal;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/orderSelector.sv ====
`default_nettype none

module orderSelector (
    input  logic           iClock,
    input  logic           arstN,
    input  logic           iSumValid,
    input  flacPkg::sumT   iSum0,
    input  flacPkg::sumT   iSum1,
    input  flacPkg::sumT   iSum2,
    input  flacPkg::sumT   iSum3,
    input  flacPkg::sumT   iSum4,
    output flacPkg::orderT oBestOrder,
    output flacPkg::sumT   oBestSum,
    output logic           oOrderValid
);

    import flacPkg::*;

    // First level winners
    orderT order01;
    sumT   sum01;
    orderT order23;
    sumT   sum23;

    // Second and final level winners
    orderT order0123;
    sumT   sum0123;
    orderT orderBest;
    sumT   sumBest;

    // Left side always holds the lower orders
    // Strict compare keeps the left entry on a tie
    always_comb begin
        order01 = orderT'(0);
        sum01   = iSum0;
        if (iSum1 < iSum0) begin
            order01 = orderT'(1);
            sum01   = iSum1;
        end
        order23 = orderT'(2);
        sum23   = iSum2;
        if (iSum3 < iSum2) begin
            order23 = orderT'(3);
            sum23   = iSum3;
        end
        order0123 = order01;
        sum0123   = sum01;
        if (sum23 < sum01) begin
            order0123 = order23;
            sum0123   = sum23;
        end
        // Order 4 only wins when strictly smaller than all others
        orderBest = order0123;
        sumBest   = sum0123;
        if (iSum4 < sum0123) begin
            orderBest = orderT'(4);
            sumBest   = iSum4;
        end
    end

    always_ff @(posedge iClock or negedge arstN) begin
        if (!arstN) begin
            oBestOrder  <= '0;
            oBestSum    <= '0;
            oOrderValid <= 1'b0;
        end else begin
            oOrderValid <= iSumValid;
            if (iSumValid) begin
                oBestOrder <= orderBest;
                oBestSum   <= sumBest;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fixedEncoderTop.sv ====
`default_nettype none

`include "flac_defs.svh"

module fixedEncoderTop (
    input  logic              iClock,
    input  logic              arstN,
    input  logic              iEnable,
    input  logic              iBlockStart,
    input  logic              iBlockEnd,
    input  flacPkg::sampleT   iSample,
    output flacPkg::residualT oResidual0,
    output flacPkg::residualT oResidual1,
    output flacPkg::residualT oResidual2,
    output flacPkg::residualT oResidual3,
    output flacPkg::residualT oResidual4,
    output logic              oResidualValid,
    output flacPkg::orderT    oBestOrder,
    output flacPkg::sumT      oBestSum,
    output logic              oOrderValid
);

    import flacPkg::*;

    // Per-order residual streams
    residualT residual [`NUM_ORDERS];
    logic     residualValid [`NUM_ORDERS];
    logic     residualLast [`NUM_ORDERS];

    // Per-order block sums
    sumT  blockSum [`NUM_ORDERS];
    logic sumValid [`NUM_ORDERS];

    // One predictor and one accumulator per order
    for (genvar k = 0; k < `NUM_ORDERS; k++) begin : gOrder

        fixedEncoder #(
            .order(k)
        ) encoder (
            .iClock         (iClock),
            .arstN          (arstN),
            .iEnable        (iEnable),
            .iBlockStart    (iBlockStart),
            .iBlockEnd      (iBlockEnd),
            .iSample        (iSample),
            .oResidual      (residual[k]),
            .oResidualValid (residualValid[k]),
            .oResidualLast  (residualLast[k])
        );

        residualAccumulator accumulator (
            .iClock         (iClock),
            .arstN          (arstN),
            .iResidual      (residual[k]),
            .iResidualValid (residualValid[k]),
            .iResidualLast  (residualLast[k]),
            .oBlockSum      (blockSum[k]),
            .oSumValid      (sumValid[k])
        );

    end

    // All accumulators finish on the same cycle, so order 0 paces the selector
    orderSelector selector (
        .iClock      (iClock),
        .arstN       (arstN),
        .iSumValid   (sumValid[0]),
        .iSum0       (blockSum[0]),
        .iSum1       (blockSum[1]),
        .iSum2       (blockSum[2]),
        .iSum3       (blockSum[3]),
        .iSum4       (blockSum[4]),
        .oBestOrder  (oBestOrder),
        .oBestSum    (oBestSum),
        .oOrderValid (oOrderValid)
    );

    // Residual outputs
    assign oResidual0 = residual[0];
    assign oResidual1 = residual[1];
    assign oResidual2 = residual[2];
    assign oResidual3 = residual[3];
    assign oResidual4 = residual[4];

    // Every encoder shares the same valid timing
    assign oResidualValid = residualValid[0];

endmodule

`default_nettype wire

// ==== dv/fixedEncoderTb.sv ====
`default_nettype none

`include "flac_defs.svh"

module fixedEncoderTb;

    import flacPkg::*;

    // Stimulus kinds of a block
    localparam logic [2:0] kindConst  = 3'd0;
    localparam logic [2:0] kindRamp   = 3'd1;
    localparam logic [2:0] kindQuad   = 3'd2;
    localparam logic [2:0] kindAlt    = 3'd3;
    localparam logic [2:0] kindRandom = 3'd4;
    localparam int numBlocks = 10;

    // One table row per block
    // Known marks hand-derived expectations
    typedef struct packed {
        logic [2:0] kind;
        sampleT     base;
        logic [4:0] length;
        logic       gaps;
        logic       known;
        orderT      expOrder;
        sumT        expSum;
    } blockT;

    typedef struct packed {
        logic  known;
        orderT order;
        sumT   sum;
    } expectT;

    // Model output for one sample
    // Due holds the cycle it must show up in
    typedef struct packed {
        logic [31:0] due;
        logic [`NUM_ORDERS-1:0][`RESIDUAL_WIDTH-1:0] res;
    } resEntryT;

    typedef struct packed {
        logic [31:0] due;
        orderT       order;
        sumT         sum;
    } orderEntryT;

    logic     iClock;
    logic     arstN;
    logic     iEnable;
    logic     iBlockStart;
    logic     iBlockEnd;
    sampleT   iSample;
    residualT oResidual0;
    residualT oResidual1;
    residualT oResidual2;
    residualT oResidual3;
    residualT oResidual4;
    logic     oResidualValid;
    orderT    oBestOrder;
    sumT      oBestSum;
    logic     oOrderValid;

    blockT       blocks [numBlocks];
    expectT      tableQ [$];
    resEntryT    resQ [$];
    orderEntryT  orderQ [$];
    int          modelHist [4];
    int          modelSums [`NUM_ORDERS];
    int          modelWarm = 0;
    logic [31:0] lfsrState = 32'h6ad7;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    int          checkCount = 0;
    int          errorCount = 0;

    fixedEncoderTop uut (
        .iClock         (iClock),
        .arstN          (arstN),
        .iEnable        (iEnable),
        .iBlockStart    (iBlockStart),
        .iBlockEnd      (iBlockEnd),
        .iSample        (iSample),
        .oResidual0     (oResidual0),
        .oResidual1     (oResidual1),
        .oResidual2     (oResidual2),
        .oResidual3     (oResidual3),
        .oResidual4     (oResidual4),
        .oResidualValid (oResidualValid),
        .oBestOrder     (oBestOrder),
        .oBestSum       (oBestSum),
        .oOrderValid    (oOrderValid)
    );

    initial begin
        iClock = 1'b0;
        forever #4 iClock = ~iClock;
    end

    always @(posedge iClock) begin
        cycleCount <= cycleCount + 1;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value     = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic sampleT sampleFor(input logic [2:0] kind, input sampleT base,
                                         input int index);
        case (kind)
            kindConst:  return base;
            kindRamp:   return sampleT'(int'(base) + 10 * index);
            kindQuad:   return sampleT'(index * index);
            // Full-scale swing is the worst case for the order 4 range
            kindAlt:    return index[0] ? 16'sh8000 : 16'sh7fff;
            kindRandom: return sampleT'(takeBits(16));
            default:    return '0;
        endcase
    endfunction

    // Order n residual as sum of (-1)^j C(n,j) x[-j]
    function automatic int binomialResidual(input int ord, input int x0);
        int acc;
        int coef;
        acc  = 0;
        coef = 1;
        for (int j = 0; j <= ord; j++) begin
            acc  = acc + coef * ((j == 0) ? x0 : modelHist[j-1]);
            coef = -coef * (ord - j) / (j + 1);
        end
        return acc;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic driveSample(input sampleT value, input logic start, input logic last);
        @(posedge iClock);
        iEnable     <= 1'b1;
        iBlockStart <= start;
        iBlockEnd   <= last;
        iSample     <= value;
    endtask

    task automatic idleCycle();
        @(posedge iClock);
        iEnable     <= 1'b0;
        iBlockStart <= 1'b0;
        iBlockEnd   <= 1'b0;
    endtask

    // Sums worked out by hand from the warm-up and difference rules
    task automatic loadTable();
        blocks[0] = '{kindConst, 16'sd100, 5'd6, 1'b0, 1'b1, 3'd1, 32'd100};
        blocks[1] = '{kindRamp, 16'sd0, 5'd8, 1'b0, 1'b1, 3'd2, 32'd10};
        blocks[2] = '{kindQuad, 16'sd0, 5'd8, 1'b0, 1'b1, 3'd3, 32'd5};
        blocks[3] = '{kindAlt, 16'sd0, 5'd8, 1'b0, 1'b1, 3'd0, 32'd262140};
        blocks[4] = '{kindRandom, 16'sd0, 5'd12, 1'b0, 1'b0, 3'd0, 32'd0};
        // Same ramp again with gaps must give the same sums
        blocks[5] = '{kindRamp, 16'sd0, 5'd8, 1'b1, 1'b1, 3'd2, 32'd10};
        blocks[6] = '{kindRandom, 16'sd0, 5'd16, 1'b1, 1'b0, 3'd0, 32'd0};
        blocks[7] = '{kindQuad, 16'sd0, 5'd8, 1'b1, 1'b1, 3'd3, 32'd5};
        blocks[8] = '{kindConst, -16'sd300, 5'd4, 1'b0, 1'b1, 3'd1, 32'd300};
        // Single sample block where all five sums tie
        blocks[9] = '{kindConst, 16'sd7, 5'd1, 1'b0, 1'b1, 3'd0, 32'd7};
    endtask

    // Monitor and reference model sample away from the driving edge
    always @(negedge iClock) begin
        resEntryT         resItem;
        orderEntryT       ordItem;
        expectT           tabItem;
        logic [`RESIDUAL_WIDTH-1:0] got [`NUM_ORDERS];
        int               idx;
        int               x0;
        int               r;
        int               best;
        got[0] = oResidual0;
        got[1] = oResidual1;
        got[2] = oResidual2;
        got[3] = oResidual3;
        got[4] = oResidual4;
        if (oResidualValid) begin
            if (resQ.size() == 0) begin
                errorCount++;
                $display("Unexpected residual valid at cycle %0d", cycleCount);
            end else begin
                resItem = resQ.pop_front();
                checkValue("oResidualValid cycle", 32'(cycleCount), resItem.due);
                for (int o = 0; o < `NUM_ORDERS; o++) begin
                    checkValue($sformatf("oResidual%0d", o), 32'(got[o]),
                               32'(resItem.res[o]));
                end
            end
        end else if (resQ.size() != 0 && resQ[0].due <= 32'(cycleCount)) begin
            errorCount++;
            $display("Residual valid missing at cycle %0d", cycleCount);
            resItem = resQ.pop_front();
        end
        if (oOrderValid) begin
            if (orderQ.size() == 0 || tableQ.size() == 0) begin
                errorCount++;
                $display("Unexpected order valid at cycle %0d", cycleCount);
            end else begin
                ordItem = orderQ.pop_front();
                tabItem = tableQ.pop_front();
                checkValue("oOrderValid cycle", 32'(cycleCount), ordItem.due);
                checkValue("oBestOrder", 32'(oBestOrder), 32'(ordItem.order));
                checkValue("oBestSum", oBestSum, ordItem.sum);
                if (tabItem.known) begin
                    checkValue("oBestOrder", 32'(oBestOrder), 32'(tabItem.order));
                    checkValue("oBestSum", oBestSum, tabItem.sum);
                end
            end
        end else if (orderQ.size() != 0 && orderQ[0].due <= 32'(cycleCount)) begin
            errorCount++;
            $display("Order valid missing at cycle %0d", cycleCount);
            ordItem = orderQ.pop_front();
        end
        // Model steps on every enable the DUT will sample at the next edge
        if (arstN && iEnable) begin
            idx = iBlockStart ? 0 : modelWarm;
            x0  = int'(iSample);
            if (iBlockStart) begin
                for (int o = 0; o < `NUM_ORDERS; o++) begin
                    modelSums[o] = 0;
                end
            end
            for (int o = 0; o < `NUM_ORDERS; o++) begin
                // Warm-up samples are their own residual
                r = (idx < o) ? x0 : binomialResidual(o, x0);
                resItem.res[o] = `RESIDUAL_WIDTH'(r);
                modelSums[o]   = modelSums[o] + ((r < 0) ? -r : r);
            end
            // Three cycles from the enable to the residual
            resItem.due = 32'(cycleCount + 3);
            resQ.push_back(resItem);
            for (int k = 3; k > 0; k--) begin
                modelHist[k] = modelHist[k-1];
            end
            modelHist[0] = x0;
            modelWarm    = (idx < 4) ? idx + 1 : 4;
            if (iBlockEnd) begin
                best = 0;
                // Strict compare so the lower order wins a tie
                for (int o = 1; o < `NUM_ORDERS; o++) begin
                    if (modelSums[o] < modelSums[best]) begin
                        best = o;
                    end
                end
                // Accumulator and selector add one cycle each
                ordItem.due   = 32'(cycleCount + 5);
                ordItem.order = orderT'(best);
                ordItem.sum   = sumT'(modelSums[best]);
                orderQ.push_back(ordItem);
            end
        end
    end

    always @(negedge iClock) begin
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run exceeded %0d cycles", cycleLimit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int gap;
        arstN       = 1'b0;
        iEnable     = 1'b0;
        iBlockStart = 1'b0;
        iBlockEnd   = 1'b0;
        iSample     = '0;
        for (int k = 0; k < 4; k++) begin
            modelHist[k] = 0;
        end
        loadTable();
        // Reset and idle cycles plus every sample with its worst gap and a margin
        cycleLimit = 8 + 50;
        for (int b = 0; b < numBlocks; b++) begin
            cycleLimit = cycleLimit + int'(blocks[b].length) * (blocks[b].gaps ? 4 : 1);
        end
        repeat (5) @(posedge iClock);
        arstN <= 1'b1;
        // Valid outputs must stay low until the first enable
        repeat (3) @(posedge iClock);
        for (int b = 0; b < numBlocks; b++) begin
            tableQ.push_back('{blocks[b].known, blocks[b].expOrder, blocks[b].expSum});
            for (int i = 0; i < int'(blocks[b].length); i++) begin
                if (blocks[b].gaps) begin
                    gap = int'(takeBits(2));
                    repeat (gap) idleCycle();
                end
                driveSample(sampleFor(blocks[b].kind, blocks[b].base, i), i == 0,
                            i == int'(blocks[b].length) - 1);
            end
        end
        idleCycle();
        while (resQ.size() != 0 || orderQ.size() != 0) begin
            @(posedge iClock);
        end
        repeat (4) @(posedge iClock);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/flacPkg.sv
verilog/fixedEncoder.sv
verilog/residualAccumulator.sv
verilog/orderSelector.sv
verilog/fixedEncoderTop.sv
dv/fixedEncoderTb.sv

// ==== Makefile ====
# Verilator simulation of the fixed predictor encoder

VERILATOR ?= verilator
TOP       ?= fixedEncoderTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= *** PASSED ***

.PHONY: sim clean

# Build, run, and fail unless the pass line is in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
